// ==== all.f ====
rtl/conv_pkg.sv
rtl/tap_if.sv
rtl/layer_sequencer.sv
rtl/window_address_gen.sv
rtl/pixel_rom.sv
rtl/coef_rom.sv
rtl/mac_array.sv
rtl/output_stage.sv
rtl/conv_layer_top.sv
tests/conv_layer_tb.sv

// ==== rtl/coef_rom.sv ====
// weight and bias ROM
// every filter's weight for the current tap, registered so that it
// lines up with the pixel; bias is a fixed per filter table
`timescale 1ns/100ps
`default_nettype none

module coef_rom #(
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3,
	parameter int CHOUT      = 4
) (
	input  wire  clk,
	input  wire  [$clog2(KERNEL_DIM*KERNEL_DIM*CHIN)-1:0] tap_index,
	output logic signed [conv_pkg::WGT_W-1:0] wgt [CHOUT],
	output logic signed [conv_pkg::ACC_W-1:0] bias [CHOUT]
);
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN;

	logic signed [conv_pkg::WGT_W-1:0] wgt_tab [CHOUT][TAPS];  // filter by tap

	initial begin
		for (int f = 0; f < CHOUT; f++)
			for (int t = 0; t < TAPS; t++)
				wgt_tab[f][t] = conv_pkg::weight_value(f, t);
	end

	always_ff @(posedge clk) begin
		for (int f = 0; f < CHOUT; f++)
			wgt[f] <= wgt_tab[f][tap_index];  // all lanes read the same tap
	end

	for (genvar f = 0; f < CHOUT; f++) begin : g_bias
		assign bias[f] = conv_pkg::bias_value(f);  // constant per filter
	end

endmodule

`default_nettype wire

// ==== rtl/conv_layer_top.sv ====
// strided 3x3 conv layer
// streams a padded image through CHOUT MAC lanes, one window per
// K*K*CHIN taps, and presents all filter results per sample pulse
`timescale 1ns/100ps
`default_nettype none

module conv_layer_top #(
	parameter int W_IN       = 10,
	parameter int WOUT       = 4,
	parameter int STRIDE     = 2,
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3,
	parameter int CHOUT      = 4
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  en,
	input  wire  ram_feedback,
	output logic sample,
	output logic finish,
	output logic [conv_pkg::OUT_W-1:0] ofm [CHOUT]
);
	localparam int TAPS   = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int ADDR_W = $clog2(W_IN * W_IN * CHIN);

	tap_if #(.TAPS(TAPS)) taps ();

	logic        [ADDR_W-1:0]          pix_addr;
	logic        [conv_pkg::PIX_W-1:0] pix;
	logic signed [conv_pkg::WGT_W-1:0] wgt  [CHOUT];
	logic signed [conv_pkg::ACC_W-1:0] bias [CHOUT];
	logic signed [conv_pkg::ACC_W-1:0] acc  [CHOUT];
	logic                              acc_valid;

	//////////////////////////////
	// control
	//////////////////////////////
	layer_sequencer #(.WOUT(WOUT), .CHIN(CHIN), .KERNEL_DIM(KERNEL_DIM)) seq_i (
		.clk(clk), .rst(rst), .en(en), .ram_feedback(ram_feedback),
		.sample(sample), .taps(taps), .finish(finish)
	);

	window_address_gen #(
		.W_IN(W_IN), .WOUT(WOUT), .STRIDE(STRIDE), .CHIN(CHIN), .KERNEL_DIM(KERNEL_DIM)
	) addr_i (
		.clk(clk), .rst(rst), .taps(taps), .pix_addr(pix_addr)
	);

	//////////////////////////////
	// ROMs
	//////////////////////////////
	pixel_rom #(.W_IN(W_IN), .CHIN(CHIN)) pix_rom_i (
		.clk(clk), .pix_addr(pix_addr), .pix(pix)
	);

	coef_rom #(.CHIN(CHIN), .KERNEL_DIM(KERNEL_DIM), .CHOUT(CHOUT)) coef_rom_i (
		.clk(clk), .tap_index(taps.tap_index), .wgt(wgt), .bias(bias)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////
	mac_array #(.CHOUT(CHOUT)) mac_i (
		.clk(clk), .rst(rst), .pix(pix), .wgt(wgt), .taps(taps),
		.acc(acc), .acc_valid(acc_valid)
	);

	output_stage #(.CHOUT(CHOUT)) out_i (
		.clk(clk), .rst(rst), .acc(acc), .acc_valid(acc_valid), .bias(bias),
		.ofm(ofm), .sample(sample)
	);

endmodule

`default_nettype wire

// ==== rtl/conv_pkg.sv ====
// conv layer package
// data widths, sequencer states and the fixed rules behind the
// image, weight and bias ROM contents
`default_nettype none

package conv_pkg;

	localparam int PIX_W = 8;   // unsigned pixel
	localparam int WGT_W = 8;   // signed weight
	localparam int ACC_W = 24;  // accumulator and bias
	localparam int OUT_W = 16;  // output feature word
	localparam int FRAC  = 2;   // fraction bits dropped at output

	typedef enum logic [1:0] {
		idle,
		run,
		done
	} seq_state_t;

	// pad ring of every channel plane is zero
	function automatic logic [PIX_W-1:0] pixel_value(input int addr, input int w_in);
		int pos;
		int row;
		int col;
		pos = addr % (w_in * w_in);  // offset inside the channel plane
		row = pos / w_in;
		col = pos % w_in;
		if (row == 0 || row == w_in - 1 || col == 0 || col == w_in - 1)
			return '0;
		return PIX_W'((addr * 7 + 3) % 32);
	endfunction

	function automatic logic signed [WGT_W-1:0] weight_value(input int f, input int t);
		return WGT_W'(((5 * f + 3 * t) % 9) - 4);  // spans -4..4
	endfunction

	function automatic logic signed [ACC_W-1:0] bias_value(input int f);
		return ACC_W'(16 * f - 24);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/layer_sequencer.sv ====
// layer sequencer
// walks taps inside a window and windows across the output plane,
// pauses on en low, raises finish once every result is out
`timescale 1ns/100ps
`default_nettype none

module layer_sequencer #(
	parameter int WOUT       = 4,
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  en,
	input  wire  ram_feedback,
	input  wire  sample,
	tap_if.seq   taps,
	output logic finish
);
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int NWIN = WOUT * WOUT;

	conv_pkg::seq_state_t state;
	logic [$clog2(TAPS)-1:0]   tap_cnt;
	logic [$clog2(WOUT)-1:0]   win_x;
	logic [$clog2(WOUT)-1:0]   win_y;
	logic [$clog2(NWIN+1)-1:0] sample_cnt;  // results already presented
	logic                      fb_latch;
	logic                      issue;

	assign issue = (state == conv_pkg::run) && en;  // pause costs whole cycles

	assign taps.tap_valid = issue;
	assign taps.first_tap = issue && (tap_cnt == 0);
	assign taps.last_tap  = issue && (tap_cnt == TAPS - 1);
	assign taps.row_last  = (win_x == WOUT - 1);
	assign taps.tap_index = tap_cnt;

	//////////////////////////////
	// tap / window walk
	//////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= conv_pkg::idle;
			tap_cnt <= '0;
			win_x   <= '0;
			win_y   <= '0;
		end else begin
			case (state)
				conv_pkg::idle: if (en) state <= conv_pkg::run;
				conv_pkg::run: begin
					if (issue) begin
						if (tap_cnt == TAPS - 1) begin
							tap_cnt <= '0;  // next window starts right away
							if (win_x == WOUT - 1) begin
								win_x <= '0;
								if (win_y == WOUT - 1) begin
									win_y <= '0;
									state <= conv_pkg::done;  // last tap of last window
								end else begin
									win_y <= win_y + 1'b1;
								end
							end else begin
								win_x <= win_x + 1'b1;
							end
						end else begin
							tap_cnt <= tap_cnt + 1'b1;
						end
					end
				end
				conv_pkg::done: state <= conv_pkg::done;  // no more taps
				default: state <= conv_pkg::idle;
			endcase
		end
	end

	//////////////////////////////
	// end of layer
	//////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample_cnt <= '0;
			fb_latch   <= 1'b0;
		end else begin
			if (sample && sample_cnt != NWIN)
				sample_cnt <= sample_cnt + 1'b1;
			if (ram_feedback)
				fb_latch <= 1'b1;  // sticky, memory has taken the layer
		end
	end

	assign finish = (sample_cnt == NWIN) && !fb_latch;

endmodule

`default_nettype wire

// ==== rtl/mac_array.sv ====
// MAC array
// one signed accumulator per filter; strobes are taken one cycle late
// to meet the ROM data, the finished window sum goes out with acc_valid
`timescale 1ns/100ps
`default_nettype none

module mac_array #(
	parameter int CHOUT = 4
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  [conv_pkg::PIX_W-1:0] pix,
	input  wire  signed [conv_pkg::WGT_W-1:0] wgt [CHOUT],
	tap_if.mac   taps,
	output logic signed [conv_pkg::ACC_W-1:0] acc [CHOUT],
	output logic acc_valid
);
	logic d_valid;  // strobes aligned with pix / wgt
	logic d_first;
	logic d_last;
	logic signed [conv_pkg::ACC_W-1:0] prod [CHOUT];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			d_valid   <= 1'b0;
			d_first   <= 1'b0;
			d_last    <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			d_valid   <= taps.tap_valid;
			d_first   <= taps.first_tap;
			d_last    <= taps.last_tap;
			acc_valid <= d_valid && d_last;  // acc holds the full sum next cycle
		end
	end

	// pixel is unsigned, widen with a zero sign bit
	always_comb begin
		for (int i = 0; i < CHOUT; i++)
			prod[i] = $signed({1'b0, pix}) * wgt[i];
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < CHOUT; i++) begin
			if (d_valid)
				acc[i] <= d_first ? prod[i] : acc[i] + prod[i];  // load on window start
		end
	end

endmodule

`default_nettype wire

// ==== rtl/output_stage.sv ====
// output stage
// bias add, ReLU, drop of FRAC bits and saturation per lane,
// then the ofm registers and the sample pulse
`timescale 1ns/100ps
`default_nettype none

module output_stage #(
	parameter int CHOUT = 4
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  signed [conv_pkg::ACC_W-1:0] acc [CHOUT],
	input  wire  acc_valid,
	input  wire  signed [conv_pkg::ACC_W-1:0] bias [CHOUT],
	output logic [conv_pkg::OUT_W-1:0] ofm [CHOUT],
	output logic sample
);
	localparam logic signed [conv_pkg::ACC_W-1:0] SAT_LIM = 2**(conv_pkg::OUT_W-1) - 1;

	logic signed [conv_pkg::ACC_W-1:0] sum    [CHOUT];
	logic signed [conv_pkg::ACC_W-1:0] scaled [CHOUT];
	logic        [conv_pkg::OUT_W-1:0] q      [CHOUT];

	always_comb begin
		for (int i = 0; i < CHOUT; i++) begin
			sum[i]    = acc[i] + bias[i];
			scaled[i] = sum[i] >>> conv_pkg::FRAC;
			if (sum[i] < 0)
				q[i] = '0;  // ReLU
			else if (scaled[i] > SAT_LIM)
				q[i] = SAT_LIM[conv_pkg::OUT_W-1:0];  // clip to 32767
			else
				q[i] = scaled[i][conv_pkg::OUT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample <= 1'b0;
			for (int i = 0; i < CHOUT; i++)
				ofm[i] <= '0;
		end else begin
			sample <= acc_valid;  // one pulse per window
			if (acc_valid) begin
				for (int i = 0; i < CHOUT; i++)
					ofm[i] <= q[i];  // held until the next window
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pixel_rom.sv ====
// image ROM
// zero padded multi channel input, one registered read per cycle
`timescale 1ns/100ps
`default_nettype none

module pixel_rom #(
	parameter int W_IN = 10,
	parameter int CHIN = 2
) (
	input  wire  clk,
	input  wire  [$clog2(W_IN*W_IN*CHIN)-1:0] pix_addr,
	output logic [conv_pkg::PIX_W-1:0] pix
);
	localparam int DEPTH = W_IN * W_IN * CHIN;

	logic [conv_pkg::PIX_W-1:0] mem [DEPTH];  // channel planes back to back

	initial begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = conv_pkg::pixel_value(a, W_IN);
	end

	always_ff @(posedge clk) begin
		pix <= mem[pix_addr];  // one cycle after the address
	end

endmodule

`default_nettype wire

// ==== rtl/tap_if.sv ====
// per-tap strobes from the layer sequencer
// seen live by the address generator, delayed inside the MAC array
`timescale 1ns/100ps
`default_nettype none

interface tap_if #(
	parameter int TAPS = 18
);
	logic                    tap_valid;  // a tap goes out this cycle
	logic                    first_tap;  // tap 0 of the window
	logic                    last_tap;   // tap TAPS-1
	logic                    row_last;   // window is the last of its output row
	logic [$clog2(TAPS)-1:0] tap_index;

	modport seq (output tap_valid, first_tap, last_tap, row_last, tap_index);
	modport addr (input tap_valid, last_tap, row_last, tap_index);
	modport mac (input tap_valid, first_tap, last_tap);

endinterface

`default_nettype wire

// ==== rtl/window_address_gen.sv ====
// window address generator
// steps the image address tap by tap through a window and moves the
// window reference by the stride once the window is done
`timescale 1ns/100ps
`default_nettype none

module window_address_gen #(
	parameter int W_IN       = 10,
	parameter int WOUT       = 4,
	parameter int STRIDE     = 2,
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3
) (
	input  wire  clk,
	input  wire  rst,
	tap_if.addr  taps,
	output logic [$clog2(W_IN*W_IN*CHIN)-1:0] pix_addr  // address of the tap to issue
);
	localparam int ADDR_W = $clog2(W_IN * W_IN * CHIN);
	localparam int KK     = KERNEL_DIM * KERNEL_DIM;

	// address steps, all taken from the last tap's position
	localparam logic [ADDR_W-1:0] ROW_STEP = ADDR_W'(W_IN - (KERNEL_DIM - 1));
	localparam logic [ADDR_W-1:0] CH_STEP  =
		ADDR_W'(W_IN * W_IN - (KERNEL_DIM - 1) * W_IN - (KERNEL_DIM - 1));
	localparam logic [ADDR_W-1:0] WIN_STEP = ADDR_W'(STRIDE);
	localparam logic [ADDR_W-1:0] ROW_WRAP = ADDR_W'(STRIDE * W_IN - (WOUT - 1) * STRIDE);

	logic [ADDR_W-1:0] ref_addr;  // top left corner of the window, channel 0
	logic [ADDR_W-1:0] ref_next;
	logic              col_end;
	logic              chan_end;

	assign col_end  = (taps.tap_index % KERNEL_DIM) == KERNEL_DIM - 1;  // last column of a row
	assign chan_end = (taps.tap_index % KK) == KK - 1;  // last tap of a channel
	assign ref_next = ref_addr + (taps.row_last ? ROW_WRAP : WIN_STEP);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ref_addr <= '0;
			pix_addr <= '0;
		end else if (taps.tap_valid) begin
			if (taps.last_tap) begin
				ref_addr <= ref_next;
				pix_addr <= ref_next;  // first tap of the next window
			end else if (chan_end) begin
				pix_addr <= pix_addr + CH_STEP;
			end else if (col_end) begin
				pix_addr <= pix_addr + ROW_STEP;
			end else begin
				pix_addr <= pix_addr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the conv layer testbench with Verilator, run it, and pass only if
# the simulation prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module conv_layer_tb -o conv_layer_sim &&
./obj_dir/conv_layer_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/conv_layer_tb.sv ====
// conv layer testbench
// directed tests for reset, a full layer, sample spacing, en pauses,
// finish and the memory feedback; a behavioural model predicts every ofm word
`timescale 1ns/100ps
`default_nettype none

module conv_layer_tb;

	localparam int W_IN       = 10;
	localparam int WOUT       = 4;
	localparam int STRIDE     = 2;
	localparam int CHIN       = 2;
	localparam int KERNEL_DIM = 3;
	localparam int CHOUT      = 4;
	localparam int TAPS       = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int NWIN       = WOUT * WOUT;
	// two layer runs, the paused one up to about twice as long, plus reset,
	// finish and feedback cycles, with a margin of three
	localparam int TIMEOUT_CYCLES = 3 * (3 * NWIN * TAPS + 200);

	logic clk;
	logic rst;
	logic en;
	logic ram_feedback;
	logic sample;
	logic finish;
	logic [conv_pkg::OUT_W-1:0] ofm [CHOUT];

	int errors;
	int checks;
	int cycles;
	int samples_seen;  // results collected in the current layer run
	int last_sample;   // cycle of the previous sample
	int low_run;       // consecutive cycles with en low
	bit check_spacing;
	logic [31:0] rng;
	conv_pkg::seq_state_t st;

	conv_layer_top #(
		.W_IN(W_IN), .WOUT(WOUT), .STRIDE(STRIDE), .CHIN(CHIN),
		.KERNEL_DIM(KERNEL_DIM), .CHOUT(CHOUT)
	) dut_i (
		.clk(clk), .rst(rst), .en(en), .ram_feedback(ram_feedback),
		.sample(sample), .finish(finish), .ofm(ofm)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			st = dut_i.seq_i.state;
			$display("timeout: no end of test after %0d cycles, sequencer in %s, %0d results seen",
				cycles, st.name(), samples_seen);
			$display("errors: %0d, checks: %0d", errors, checks);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////
	task automatic model_ofm(input int ox, input int oy, input int f,
			output logic [conv_pkg::OUT_W-1:0] q);
		int base;
		int addr;
		int t;
		int sum;
		base = STRIDE * (oy * W_IN + ox);  // window corner, channel 0
		sum  = 0;
		for (int c = 0; c < CHIN; c++)
			for (int r = 0; r < KERNEL_DIM; r++)
				for (int k = 0; k < KERNEL_DIM; k++) begin
					t    = (c * KERNEL_DIM + r) * KERNEL_DIM + k;  // channel, row, column
					addr = base + c * W_IN * W_IN + r * W_IN + k;
					sum += int'(conv_pkg::pixel_value(addr, W_IN)) *
						int'(conv_pkg::weight_value(f, t));
				end
		sum += int'(conv_pkg::bias_value(f));
		if (sum < 0)
			q = '0;  // ReLU
		else if ((sum >>> conv_pkg::FRAC) > 32767)
			q = 16'd32767;
		else
			q = conv_pkg::OUT_W'(sum >>> conv_pkg::FRAC);
	endtask

	task automatic check_window(input int idx);
		logic [conv_pkg::OUT_W-1:0] exp_q;
		for (int f = 0; f < CHOUT; f++) begin
			model_ofm(idx % WOUT, idx / WOUT, f, exp_q);  // raster order
			checks++;
			if (ofm[f] !== exp_q) begin
				$display("ERROR %0t: window %0d filter %0d ofm %0d, expected %0d",
					$time, idx, f, ofm[f], exp_q);
				errors++;
			end
		end
	endtask

	// watch one cycle with outputs taken at the negedge
	task automatic monitor_cycle();
		@(negedge clk);
		low_run = en ? 0 : low_run + 1;
		checks++;
		if (finish !== 1'b0 && samples_seen < NWIN) begin
			$display("ERROR %0t: finish high with %0d of %0d results out",
				$time, samples_seen, NWIN);
			errors++;
		end
		if (sample) begin
			checks++;
			if (samples_seen >= NWIN) begin
				$display("ERROR %0t: sample beyond the %0d results of the layer", $time, NWIN);
				errors++;
			end else begin
				check_window(samples_seen);
			end
			if (low_run > 3) begin
				$display("ERROR %0t: sample after %0d cycles with en low", $time, low_run);
				errors++;
			end
			if (check_spacing && samples_seen > 0 && cycles - last_sample != TAPS) begin
				$display("ERROR %0t: samples %0d cycles apart, expected %0d",
					$time, cycles - last_sample, TAPS);
				errors++;
			end
			last_sample = cycles;
			samples_seen++;
		end
	endtask

	task automatic check_idle_outputs();
		checks++;
		if (sample !== 1'b0 || finish !== 1'b0) begin
			$display("ERROR %0t: sample %b finish %b while idle", $time, sample, finish);
			errors++;
		end
		for (int f = 0; f < CHOUT; f++)
			if (ofm[f] !== '0) begin
				$display("ERROR %0t: ofm[%0d] = %0d while idle", $time, f, ofm[f]);
				errors++;
			end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic reset_test();
		@(posedge clk);
		en  <= 1'b0;
		rst <= 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) begin  // en still low, nothing moves
			@(negedge clk);
			check_idle_outputs();
		end
		samples_seen = 0;
		low_run      = 0;
	endtask

	task automatic full_layer_test();
		check_spacing = 1'b1;
		while (samples_seen < NWIN) begin
			@(posedge clk);
			en <= 1'b1;
			monitor_cycle();
		end
	endtask

	task automatic finish_test();
		@(negedge clk);
		checks++;
		if (finish !== 1'b1) begin
			$display("ERROR %0t: finish low on the cycle after the last sample", $time);
			errors++;
		end
		repeat (100) begin
			monitor_cycle();  // flags any extra sample
			if (finish !== 1'b1) begin
				$display("ERROR %0t: finish dropped without feedback", $time);
				errors++;
			end
		end
	endtask

	task automatic feedback_test();
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		repeat (20) begin
			@(negedge clk);
			checks++;
			if (finish !== 1'b0) begin
				$display("ERROR %0t: finish high after ram_feedback", $time);
				errors++;
			end
		end
	endtask

	task automatic pause_test();
		int pause_left;
		pause_left    = 0;
		check_spacing = 1'b0;  // pauses stretch the spacing
		while (samples_seen < NWIN) begin
			@(posedge clk);
			rng = xorshift(rng);
			if (pause_left > 0) begin
				en <= 1'b0;
				pause_left--;
			end else if (rng[2:0] == 3'd0) begin
				en <= 1'b0;
				pause_left = int'(rng[6:4]);  // stretch of 1 to 8 cycles
			end else begin
				en <= 1'b1;
			end
			monitor_cycle();
		end
		@(posedge clk);
		en <= 1'b1;
	endtask

	initial begin
		rst           <= 1'b0;
		en            <= 1'b0;
		ram_feedback  <= 1'b0;
		cycles        <= 0;
		errors        = 0;
		checks        = 0;
		samples_seen  = 0;
		last_sample   = 0;
		low_run       = 0;
		check_spacing = 1'b0;
		rng           = 32'h6192;

		$display("reset");
		reset_test();
		$display("full layer with en high");
		full_layer_test();
		$display("finish");
		finish_test();
		$display("ram feedback");
		feedback_test();
		$display("layer with en pauses");
		reset_test();
		pause_test();
		finish_test();

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
